//--- source/ddr_ccc_pkg.sv
package ddr_ccc_pkg;

	// directed ccc codes
	localparam logic [6:0] P_CCC_SETMWL = 7'h09;
	localparam logic [6:0] P_CCC_SETMRL = 7'h0A;
	localparam logic [6:0] P_CCC_GETMWL = 7'h0B;
	localparam logic [6:0] P_CCC_GETMRL = 7'h0C;

	localparam logic [1:0] P_PRE_CMD  = 2'b01;
	localparam logic [1:0] P_PRE_DATA = 2'b11;
	localparam logic [1:0] P_PRE_CRC  = 2'b01;

	localparam logic [3:0] P_CRC_TOKEN = 4'b1100;
	localparam logic [4:0] P_CRC_INIT  = 5'b11111;
	localparam int         P_WORD_BITS = 20;

	// command payload minus the trailing pad bit
	typedef struct packed {
		logic       rnw;
		logic [6:0] ccc_code;
		logic [6:0] addr;
	} ccc_cmd_t;

	typedef struct packed {
		logic [15:0] payload;
		logic [1:0]  preamble;
		logic        parity_ok;
	} rx_word_t;

	typedef enum logic [1:0] {
		RX_CMD,
		RX_DATA,
		RX_CRC
	} rx_mode_t;

	// {xor of odd bits, inverted xor of even bits}
	function automatic logic [1:0] ddr_parity(input logic [15:0] data);
		logic odd;
		logic even;
		odd = 1'b0;
		even = 1'b0;
		for (int i = 0; i < 16; i += 2)
		begin
			even ^= data[i];
			odd ^= data[i + 1];
		end
		return {odd, ~even};
	endfunction

	// x^5 + x^2 + 1 applied msb first
	function automatic logic [4:0] crc5_byte(input logic [4:0] crc_in, input logic [7:0] data);
		logic [4:0] crc;
		logic       fb;
		crc = crc_in;
		for (int i = 7; i >= 0; i--)
		begin
			fb = crc[4] ^ data[i];
			crc = {crc[3:0], 1'b0} ^ {2'b00, fb, 1'b0, fb};
		end
		return crc;
	endfunction

endpackage

//--- source/scl_edge_detect.sv
module scl_edge_detect #(
	parameter int SYNC_STAGES = 2
) (
	input  logic i_sys_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	output logic o_scl_pos,
	output logic o_scl_neg
);

	logic [SYNC_STAGES-1:0] scl_sync;
	logic                   scl_cur;
	logic                   scl_prev;

	assign scl_cur = scl_sync[SYNC_STAGES-1];

	// scl idles high on the bus
	always_ff @(posedge i_sys_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			scl_sync  <= '1;
			scl_prev  <= 1'b1;
			o_scl_pos <= 1'b0;
			o_scl_neg <= 1'b0;
		end
		else
		begin
			scl_sync  <= {scl_sync[SYNC_STAGES-2:0], i_scl};
			scl_prev  <= scl_cur;
			o_scl_pos <= scl_cur & ~scl_prev;
			o_scl_neg <= ~scl_cur & scl_prev;
		end
	end

endmodule

//--- source/target_rx.sv
module target_rx #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                  i_sys_clk,
	input  logic                  i_rst_n,
	input  logic                  i_sda,
	input  logic                  i_scl_pos,
	input  logic                  i_scl_neg,
	input  logic                  i_rx_en,
	input  ddr_ccc_pkg::rx_mode_t i_rx_mode,
	output ddr_ccc_pkg::rx_word_t o_rx_word,
	output logic                  o_crc_ok,
	output logic                  o_rx_done
);

	localparam int WORD_BITS = ddr_ccc_pkg::P_WORD_BITS;

	logic [SYNC_STAGES-1:0] sda_sync;
	logic                   sda_bit;
	logic                   scl_edge;
	logic [WORD_BITS-2:0]   shift_q;
	logic [WORD_BITS-1:0]   word_next;
	logic [15:0]            payload_next;
	logic [4:0]             bit_cnt;
	logic                   word_end;
	logic [4:0]             crc_run;
	logic                   crc_match;

	assign sda_bit      = sda_sync[SYNC_STAGES-1];
	assign scl_edge     = i_scl_pos | i_scl_neg;
	assign word_next    = {shift_q, sda_bit};
	assign payload_next = word_next[17:2];
	assign word_end     = i_rx_en && scl_edge && (bit_cnt == 5'(WORD_BITS - 1));

	// crc word carries the token in [17:14] and the crc-5 in [13:9]
	assign crc_match = (word_next[17:14] == ddr_ccc_pkg::P_CRC_TOKEN) &&
		(word_next[13:9] == crc_run);

	always_ff @(posedge i_sys_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			sda_sync  <= '1;
			bit_cnt   <= '0;
			crc_run   <= ddr_ccc_pkg::P_CRC_INIT;
			o_crc_ok  <= 1'b0;
			o_rx_done <= 1'b0;
		end
		else
		begin
			sda_sync  <= {sda_sync[SYNC_STAGES-2:0], i_sda};
			o_rx_done <= word_end;
			if (!i_rx_en)
			begin
				bit_cnt <= '0;
				crc_run <= ddr_ccc_pkg::P_CRC_INIT;
			end
			else if (word_end)
			begin
				bit_cnt  <= '0;
				o_crc_ok <= (i_rx_mode == ddr_ccc_pkg::RX_CRC) && crc_match;
				// high byte first
				if (i_rx_mode == ddr_ccc_pkg::RX_DATA)
					crc_run <= ddr_ccc_pkg::crc5_byte(
						ddr_ccc_pkg::crc5_byte(crc_run, payload_next[15:8]),
						payload_next[7:0]);
			end
			else if (scl_edge)
			begin
				bit_cnt <= bit_cnt + 5'd1;
			end
		end
	end

	always_ff @(posedge i_sys_clk)
	begin
		if (i_rx_en && scl_edge)
			shift_q <= word_next[WORD_BITS-2:0];
		if (word_end)
		begin
			o_rx_word.payload   <= payload_next;
			o_rx_word.preamble  <= word_next[WORD_BITS-1:WORD_BITS-2];
			o_rx_word.parity_ok <= (word_next[1:0] == ddr_ccc_pkg::ddr_parity(payload_next));
		end
	end

endmodule

//--- source/target_tx.sv
module target_tx (
	input  logic        i_sys_clk,
	input  logic        i_rst_n,
	input  logic        i_scl_pos,
	input  logic        i_scl_neg,
	input  logic        i_tx_en,
	input  logic [15:0] i_tx_data,
	output logic        o_sda,
	output logic        o_sda_oe,
	output logic        o_tx_done
);

	localparam int FRAME_BITS = 2 * ddr_ccc_pkg::P_WORD_BITS;

	logic [FRAME_BITS-1:0] frame;
	logic [FRAME_BITS-2:0] shift_q;
	logic [4:0]            crc;
	logic [5:0]            bit_cnt;
	logic                  scl_edge;
	logic                  last_edge;

	assign crc = ddr_ccc_pkg::crc5_byte(
		ddr_ccc_pkg::crc5_byte(ddr_ccc_pkg::P_CRC_INIT, i_tx_data[15:8]), i_tx_data[7:0]);

	// data word, then crc word padded with zeros
	assign frame = {ddr_ccc_pkg::P_PRE_DATA, i_tx_data, ddr_ccc_pkg::ddr_parity(i_tx_data),
		ddr_ccc_pkg::P_PRE_CRC, ddr_ccc_pkg::P_CRC_TOKEN, crc, 9'd0};

	assign scl_edge  = i_scl_pos | i_scl_neg;
	assign last_edge = (bit_cnt == 6'(FRAME_BITS - 1));

	always_ff @(posedge i_sys_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_sda     <= 1'b1;
			o_sda_oe  <= 1'b0;
			o_tx_done <= 1'b0;
			bit_cnt   <= '0;
		end
		else
		begin
			o_tx_done <= 1'b0;
			if (i_tx_en)
			begin
				o_sda    <= frame[FRAME_BITS-1];
				o_sda_oe <= 1'b1;
				bit_cnt  <= '0;
			end
			else if (o_sda_oe && scl_edge)
			begin
				if (last_edge)
				begin
					// release the line
					o_sda     <= 1'b1;
					o_sda_oe  <= 1'b0;
					o_tx_done <= 1'b1;
					bit_cnt   <= '0;
				end
				else
				begin
					o_sda   <= shift_q[FRAME_BITS-2];
					bit_cnt <= bit_cnt + 6'd1;
				end
			end
		end
	end

	always_ff @(posedge i_sys_clk)
	begin
		if (i_tx_en)
			shift_q <= frame[FRAME_BITS-2:0];
		else if (o_sda_oe && scl_edge)
			shift_q <= {shift_q[FRAME_BITS-3:0], 1'b0};
	end

endmodule

//--- source/ccc_target.sv
module ccc_target #(
	parameter logic [6:0] TARGET_ADDR = 7'h3A
) (
	input  logic                  i_sys_clk,
	input  logic                  i_rst_n,
	input  logic                  i_engine_en,
	input  ddr_ccc_pkg::rx_word_t i_rx_word,
	input  logic                  i_crc_ok,
	input  logic                  i_rx_done,
	input  logic                  i_tx_done,
	output logic                  o_rx_en,
	output ddr_ccc_pkg::rx_mode_t o_rx_mode,
	output logic                  o_tx_en,
	output logic [15:0]           o_tx_data,
	output logic                  o_engine_done,
	output logic                  o_error,
	output logic [15:0]           o_mwl,
	output logic [15:0]           o_mrl
);

	typedef enum logic [2:0] {IDLE, CMD, DATA, CRC, SEND, FINISH} state_t;

	state_t                state;
	ddr_ccc_pkg::ccc_cmd_t cmd;
	logic                  cmd_ok;
	logic                  is_set;
	logic                  is_get;
	logic                  sel_mrl;
	logic                  data_err;
	logic                  crc_pass;
	logic [15:0]           pending;

	// last payload bit is padding
	assign cmd    = i_rx_word.payload[15:1];
	assign cmd_ok = (i_rx_word.preamble == ddr_ccc_pkg::P_PRE_CMD) && i_rx_word.parity_ok;
	assign is_set = !cmd.rnw && (cmd.ccc_code == ddr_ccc_pkg::P_CCC_SETMWL ||
		cmd.ccc_code == ddr_ccc_pkg::P_CCC_SETMRL);
	assign is_get = cmd.rnw && (cmd.ccc_code == ddr_ccc_pkg::P_CCC_GETMWL ||
		cmd.ccc_code == ddr_ccc_pkg::P_CCC_GETMRL);
	assign crc_pass = (i_rx_word.preamble == ddr_ccc_pkg::P_PRE_CRC) && i_crc_ok && !data_err;

	assign o_rx_en       = (state == CMD) || (state == DATA) || (state == CRC);
	assign o_engine_done = (state == FINISH);

	always_comb
	begin
		case (state)
			DATA:    o_rx_mode = ddr_ccc_pkg::RX_DATA;
			CRC:     o_rx_mode = ddr_ccc_pkg::RX_CRC;
			default: o_rx_mode = ddr_ccc_pkg::RX_CMD;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state    <= IDLE;
			o_tx_en  <= 1'b0;
			o_error  <= 1'b0;
			o_mwl    <= '0;
			o_mrl    <= '0;
			sel_mrl  <= 1'b0;
			data_err <= 1'b0;
		end
		else
		begin
			o_tx_en <= 1'b0;
			case (state)
				IDLE:
				begin
					if (i_engine_en)
					begin
						state    <= CMD;
						o_error  <= 1'b0;
						data_err <= 1'b0;
					end
				end
				CMD:
				begin
					if (i_rx_done)
					begin
						sel_mrl <= (cmd.ccc_code == ddr_ccc_pkg::P_CCC_SETMRL) ||
							(cmd.ccc_code == ddr_ccc_pkg::P_CCC_GETMRL);
						if (!cmd_ok)
						begin
							o_error <= 1'b1;
							state   <= FINISH;
						end
						// commands for other targets are dropped quietly
						else if (cmd.addr != TARGET_ADDR)
							state <= IDLE;
						else if (is_set)
							state <= DATA;
						else if (is_get)
						begin
							o_tx_en <= 1'b1;
							state   <= SEND;
						end
						else
						begin
							o_error <= 1'b1;
							state   <= FINISH;
						end
					end
				end
				DATA:
				begin
					// bad data word still waits for the crc word
					if (i_rx_done)
					begin
						data_err <= (i_rx_word.preamble != ddr_ccc_pkg::P_PRE_DATA) ||
							!i_rx_word.parity_ok;
						state    <= CRC;
					end
				end
				CRC:
				begin
					if (i_rx_done)
					begin
						if (crc_pass && sel_mrl)
							o_mrl <= pending;
						else if (crc_pass)
							o_mwl <= pending;
						o_error <= !crc_pass;
						state   <= FINISH;
					end
				end
				SEND:
				begin
					if (i_tx_done)
						state <= FINISH;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_sys_clk)
	begin
		if (state == DATA && i_rx_done)
			pending <= i_rx_word.payload;
		if (state == CMD && i_rx_done)
			o_tx_data <= (cmd.ccc_code == ddr_ccc_pkg::P_CCC_GETMRL) ? o_mrl : o_mwl;
	end

endmodule

//--- source/ddr_target_top.sv
module ddr_target_top #(
	parameter int         SYNC_STAGES = 2,
	parameter logic [6:0] TARGET_ADDR = 7'h3A
) (
	input  logic        i_sys_clk,
	input  logic        i_rst_n,
	input  logic        i_engine_en,
	input  logic        i_scl,
	input  logic        i_sda,
	output logic        o_sda,
	output logic        o_sda_oe,
	output logic        o_engine_done,
	output logic        o_error,
	output logic [15:0] o_mwl,
	output logic [15:0] o_mrl
);

	logic                  scl_pos;
	logic                  scl_neg;
	logic                  rx_en;
	ddr_ccc_pkg::rx_mode_t rx_mode;
	ddr_ccc_pkg::rx_word_t rx_word;
	logic                  crc_ok;
	logic                  rx_done;
	logic                  tx_en;
	logic [15:0]           tx_data;
	logic                  tx_done;

	scl_edge_detect #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_scl_edge (
		.i_sys_clk (i_sys_clk),
		.i_rst_n   (i_rst_n),
		.i_scl     (i_scl),
		.o_scl_pos (scl_pos),
		.o_scl_neg (scl_neg)
	);

	// same sync depth as scl keeps sda aligned to the edge pulses
	target_rx #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_rx (
		.i_sys_clk (i_sys_clk),
		.i_rst_n   (i_rst_n),
		.i_sda     (i_sda),
		.i_scl_pos (scl_pos),
		.i_scl_neg (scl_neg),
		.i_rx_en   (rx_en),
		.i_rx_mode (rx_mode),
		.o_rx_word (rx_word),
		.o_crc_ok  (crc_ok),
		.o_rx_done (rx_done)
	);

	target_tx u_tx (
		.i_sys_clk (i_sys_clk),
		.i_rst_n   (i_rst_n),
		.i_scl_pos (scl_pos),
		.i_scl_neg (scl_neg),
		.i_tx_en   (tx_en),
		.i_tx_data (tx_data),
		.o_sda     (o_sda),
		.o_sda_oe  (o_sda_oe),
		.o_tx_done (tx_done)
	);

	ccc_target #(
		.TARGET_ADDR (TARGET_ADDR)
	) u_ccc (
		.i_sys_clk     (i_sys_clk),
		.i_rst_n       (i_rst_n),
		.i_engine_en   (i_engine_en),
		.i_rx_word     (rx_word),
		.i_crc_ok      (crc_ok),
		.i_rx_done     (rx_done),
		.i_tx_done     (tx_done),
		.o_rx_en       (rx_en),
		.o_rx_mode     (rx_mode),
		.o_tx_en       (tx_en),
		.o_tx_data     (tx_data),
		.o_engine_done (o_engine_done),
		.o_error       (o_error),
		.o_mwl         (o_mwl),
		.o_mrl         (o_mrl)
	);

endmodule

//--- verif/ddr_target_tb.sv
module ddr_target_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] TARGET_ADDR = 7'h3A;
	localparam int         DONE_WAIT   = 64;
	localparam int         IDLE_WAIT   = 40;

	// corruption kinds from the input file
	localparam logic [2:0] K_PARITY = 3'd1;
	localparam logic [2:0] K_CRC    = 3'd2;
	localparam logic [2:0] K_ADDR   = 3'd3;
	localparam logic [2:0] K_CODE   = 3'd4;

	typedef struct packed {
		logic        rnw;
		logic [6:0]  code;
		logic [6:0]  addr;
		logic [15:0] data;
		logic [2:0]  kind;
	} vector_t;

	logic        i_sys_clk;
	logic        i_rst_n;
	logic        i_engine_en;
	logic        i_scl;
	logic        i_sda;
	logic        o_sda;
	logic        o_sda_oe;
	logic        o_engine_done;
	logic        o_error;
	logic [15:0] o_mwl;
	logic [15:0] o_mrl;

	vector_t     vectors[$];
	logic        vectors_loaded;
	logic [15:0] mwl_model = '0;
	logic [15:0] mrl_model = '0;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	// written by the monitor only
	int          done_count = 0;
	int          oe_cycles = 0;
	logic        done_error;
	logic [15:0] done_mwl;
	logic [15:0] done_mrl;

	ddr_target_top DUT (
		.i_sys_clk     (i_sys_clk),
		.i_rst_n       (i_rst_n),
		.i_engine_en   (i_engine_en),
		.i_scl         (i_scl),
		.i_sda         (i_sda),
		.o_sda         (o_sda),
		.o_sda_oe      (o_sda_oe),
		.o_engine_done (o_engine_done),
		.o_error       (o_error),
		.o_mwl         (o_mwl),
		.o_mrl         (o_mrl)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #20 i_sys_clk = ~i_sys_clk;
	end

	always @(negedge i_sys_clk)
	begin
		if (o_engine_done)
		begin
			done_count++;
			done_error = o_error;
			done_mwl = o_mwl;
			done_mrl = o_mrl;
		end
		if (o_sda_oe)
			oe_cycles++;
	end

	always @(posedge i_sys_clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("run stopped after %0d cycles, transactions did not complete", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// {xor of odd payload bits, inverted xor of even payload bits}
	function automatic logic [1:0] parity_bits(input logic [15:0] d);
		return {^(d & 16'hAAAA), ~^(d & 16'h5555)};
	endfunction

	function automatic logic [4:0] crc5_model(input logic [15:0] d);
		logic [4:0] crc;
		logic       fb;
		int         i;
		crc = 5'b11111;
		// high byte first and each byte msb first
		for (i = 15; i >= 0; i--)
		begin
			fb = crc[4] ^ d[i];
			crc = {crc[3:0], 1'b0};
			if (fb)
				crc = crc ^ 5'b00101;
		end
		return crc;
	endfunction

	function automatic logic [19:0] command_word(input logic rnw, input logic [6:0] code,
		input logic [6:0] addr);
		logic [15:0] payload;
		payload = {rnw, code, addr, 1'b0};
		return {2'b01, payload, parity_bits(payload)};
	endfunction

	function automatic logic [19:0] data_word(input logic [15:0] d);
		return {2'b11, d, parity_bits(d)};
	endfunction

	function automatic logic [19:0] crc_word(input logic [15:0] d);
		return {2'b01, 4'b1100, crc5_model(d), 9'd0};
	endfunction

	task automatic check_value(input string name, input logic [39:0] got,
		input logic [39:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("%0t ns: %s", $time, what);
		end
	endtask

	task automatic load_vectors(output logic ok);
		int              fd;
		logic [8*96-1:0] line;
		logic [31:0]     f_rnw;
		logic [31:0]     f_code;
		logic [31:0]     f_addr;
		logic [31:0]     f_data;
		logic [31:0]     f_kind;
		vector_t         v;
		fd = $fopen("verif/ddr_target_input.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			line = '0;
			while ($fgets(line, fd) > 0)
			begin
				// header lines fail the scan and are skipped
				if ($sscanf(line, "%h %h %h %h %h", f_rnw, f_code, f_addr, f_data, f_kind) == 5)
				begin
					v.rnw = f_rnw[0];
					v.code = f_code[6:0];
					v.addr = f_addr[6:0];
					v.data = f_data[15:0];
					v.kind = f_kind[2:0];
					vectors.push_back(v);
				end
				line = '0;
			end
			$fclose(fd);
		end
	endtask

	// sda moves 4 clocks ahead of the scl toggle
	task automatic send_bit(input logic b);
		@(posedge i_sys_clk);
		i_sda <= b;
		repeat (4) @(posedge i_sys_clk);
		i_scl <= ~i_scl;
		repeat (3) @(posedge i_sys_clk);
	endtask

	task automatic send_word(input logic [19:0] w);
		int i;
		for (i = 19; i >= 0; i--)
			send_bit(w[i]);
	endtask

	// scl keeps toggling only while the target drives sda
	task automatic sample_bit(output logic b, output logic oe);
		repeat (4) @(posedge i_sys_clk);
		@(negedge i_sys_clk);
		b = o_sda;
		oe = o_sda_oe;
		if (oe)
		begin
			@(posedge i_sys_clk);
			i_scl <= ~i_scl;
			repeat (3) @(posedge i_sys_clk);
		end
	endtask

	task automatic wait_done(input int since, output logic seen);
		int n;
		n = 0;
		while (done_count == since && n < DONE_WAIT)
		begin
			@(posedge i_sys_clk);
			n++;
		end
		seen = (done_count != since);
	endtask

	task automatic run_transaction(input vector_t v);
		logic [6:0]  code;
		logic [6:0]  addr;
		logic [19:0] cmd_w;
		logic [19:0] data_w;
		logic [19:0] crc_w;
		logic [39:0] frame_got;
		logic [15:0] read_val;
		logic        bit_v;
		logic        oe_v;
		logic        seen;
		logic        known;
		logic        exp_err;
		int          n_bits;
		int          done_before;
		int          oe_before;
		code = v.code;
		addr = v.addr;
		if (v.kind == K_ADDR)
			addr = addr ^ 7'h40;
		if (v.kind == K_CODE)
			code = code | 7'h60;
		if (v.rnw)
			known = (code == 7'h0B) || (code == 7'h0C);
		else
			known = (code == 7'h09) || (code == 7'h0A);
		exp_err = !known || (v.kind == K_PARITY) || (!v.rnw && v.kind == K_CRC);
		read_val = (code == 7'h0C) ? mrl_model : mwl_model;
		cmd_w = command_word(v.rnw, code, addr);
		data_w = data_word(v.data);
		crc_w = crc_word(v.data);
		// reads carry the parity fault in the command word
		if (v.kind == K_PARITY && v.rnw)
			cmd_w[0] = ~cmd_w[0];
		if (v.kind == K_PARITY && !v.rnw)
			data_w[1] = ~data_w[1];
		if (v.kind == K_CRC)
			crc_w[9] = ~crc_w[9];
		done_before = done_count;
		oe_before = oe_cycles;
		frame_got = '0;
		n_bits = 0;

		@(posedge i_sys_clk);
		i_engine_en <= 1'b1;
		@(posedge i_sys_clk);
		i_engine_en <= 1'b0;
		send_word(cmd_w);
		if (!v.rnw)
		begin
			send_word(data_w);
			send_word(crc_w);
		end
		else
		begin
			oe_v = 1'b1;
			while (oe_v && n_bits < 48)
			begin
				sample_bit(bit_v, oe_v);
				if (oe_v)
				begin
					frame_got = {frame_got[38:0], bit_v};
					n_bits++;
				end
			end
		end
		@(posedge i_sys_clk);
		i_sda <= 1'b1;

		if (addr != TARGET_ADDR)
		begin
			repeat (IDLE_WAIT) @(posedge i_sys_clk);
			check_true(done_count == done_before,
				"engine done pulsed for a command to another address");
			check_true(oe_cycles == oe_before, "sda driven for a command to another address");
		end
		else
		begin
			wait_done(done_before, seen);
			check_true(seen, "no engine done pulse within the wait");
			if (seen)
			begin
				check_value("o_engine_done pulses", done_count - done_before, 1);
				check_value("o_error", done_error, exp_err);
				if (!exp_err && !v.rnw && code == 7'h09)
					mwl_model = v.data;
				if (!exp_err && !v.rnw && code == 7'h0A)
					mrl_model = v.data;
				check_value("o_mwl", done_mwl, mwl_model);
				check_value("o_mrl", done_mrl, mrl_model);
			end
			if (v.rnw && !exp_err)
			begin
				check_value("o_sda bit count", n_bits, 40);
				check_value("o_sda", frame_got, {data_word(read_val), crc_word(read_val)});
			end
			else
			begin
				check_value("o_sda_oe cycles", oe_cycles - oe_before, 0);
			end
		end
		@(negedge i_sys_clk);
		check_value("o_mwl", o_mwl, mwl_model);
		check_value("o_mrl", o_mrl, mrl_model);
	endtask

	initial
	begin
		i_rst_n = 1'b0;
		i_engine_en = 1'b0;
		i_scl = 1'b1;
		i_sda = 1'b1;
		load_vectors(vectors_loaded);
		if (!vectors_loaded)
		begin
			$display("cannot open the stimulus file verif/ddr_target_input.txt");
			$display("Some tests failed");
		end
		else
		begin
			cycle_limit = (vectors.size() * 60 * 8 * 3) / 2;
			repeat (3) @(posedge i_sys_clk);
			i_rst_n <= 1'b1;
			repeat (2) @(posedge i_sys_clk);

			// idle bus before any command
			@(negedge i_sys_clk);
			check_value("o_mwl", o_mwl, 16'h0000);
			check_value("o_mrl", o_mrl, 16'h0000);
			check_value("o_sda_oe", o_sda_oe, 1'b0);
			check_value("o_sda", o_sda, 1'b1);
			check_value("o_engine_done", o_engine_done, 1'b0);
			check_value("o_error", o_error, 1'b0);

			foreach (vectors[i])
				run_transaction(vectors[i]);

			$display("checks run: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("All tests passed");
			else
				$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verif/ddr_target_input.txt
# columns in hex: rnw code addr data kind
# kind 0 none, 1 parity flip, 2 crc flip, 3 wrong address, 4 unknown code
1 0b 3a 0000 0
0 09 3a a5c3 0
0 0a 3a 1234 0
1 0b 3a 0000 0
1 0c 3a 0000 0
0 09 3a ffff 1
0 0a 3a 0f0f 2
1 0b 3a 0000 0
0 09 3a beef 3
0 0a 3a 7e81 0
0 0a 3a 5555 4
1 0c 3a 0000 3
1 0c 3a 0000 0
1 0b 3a 0000 1
0 09 3a 8001 0
1 0b 3a 0000 0
0 0a 3a 0000 0
1 0c 3a 0000 4

//--- ddr_target.f
source/ddr_ccc_pkg.sv
source/scl_edge_detect.sv
source/target_rx.sv
source/target_tx.sv
source/ccc_target.sv
source/ddr_target_top.sv
verif/ddr_target_tb.sv

//--- Bender.yml
package:
  name: ddr_target

sources:
  - source/ddr_ccc_pkg.sv
  - source/scl_edge_detect.sv
  - source/target_rx.sv
  - source/target_tx.sv
  - source/ccc_target.sv
  - source/ddr_target_top.sv
  - target: test
    files:
      - verif/ddr_target_tb.sv
